/* Makefile */
TOP = lsu_cluster_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

# A simulator abort counts as a failure too
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* project.f */
verilog/gpu_data_pkg.sv
verilog/gpu_ctrl_pkg.sv
verilog/lsu.sv
verilog/mem_arbiter.sv
verilog/data_memory.sv
verilog/warp_scheduler.sv
verilog/lsu_cluster_top.sv
verification/lsu_cluster_chk.sv
verification/lsu_cluster_tb.sv

/* verification/lsu_cluster_chk.sv */
`timescale 1ns/1ps

module lsu_cluster_chk
    import gpu_data_pkg::*;
#(
    parameter int NUM_THREADS = 4
) (
    input logic                   clk,
    input logic                   reset,
    input logic [NUM_THREADS-1:0] mem_read_valid,
    input logic [NUM_THREADS-1:0] mem_read_ready,
    input logic [NUM_THREADS-1:0] mem_write_valid,
    input logic [NUM_THREADS-1:0] mem_write_ready,
    input logic                   mem_valid,
    input logic                   mem_ready,
    input data_memory_address_t   mem_address
);

    // Each memory answer reaches exactly one thread that still holds its request
    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        mem_ready |-> $onehot(mem_read_ready | mem_write_ready))
        else $error("memory answer did not reach exactly one requesting thread");

    // A served thread drops its request, so it is answered only once
    a_ready_once: assert property (@(posedge clk) disable iff (reset)
        ((mem_read_valid | mem_write_valid) & $past(mem_read_ready | mem_write_ready)) == '0)
        else $error("thread kept its request after being answered");

    // Each thread keeps its valid up until its own ready
    a_valid_held: assert property (@(posedge clk) disable iff (reset)
        (($past(mem_read_valid & ~mem_read_ready) & ~mem_read_valid) |
         ($past(mem_write_valid & ~mem_write_ready) & ~mem_write_valid)) == '0)
        else $error("a thread dropped its valid before its ready");

    a_address_stable: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> $stable(mem_address))
        else $error("mem_address changed while the access was pending");

endmodule

bind mem_arbiter lsu_cluster_chk #(.NUM_THREADS(NUM_THREADS)) u_chk (
    .clk(clk), .reset(reset),
    .mem_read_valid(mem_read_valid), .mem_read_ready(mem_read_ready),
    .mem_write_valid(mem_write_valid), .mem_write_ready(mem_write_ready),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_address(mem_address)
);

/* verification/lsu_cluster_tb.sv */
`timescale 1ns/1ps

module lsu_cluster_tb
    import gpu_data_pkg::*, gpu_ctrl_pkg::*;
();

    localparam int NUM_THREADS = 4;
    localparam int NUM_RANDOM  = 193;
    // Seven directed instructions plus the random ones, each far below 64 cycles
    localparam int NUM_INSTR   = NUM_RANDOM + 7;
    localparam int MAX_CYCLES  = NUM_INSTR * 64;

    logic                    clk;
    logic                    reset;
    logic                    issue_req;
    mem_op_t                 issue_op;
    logic  [NUM_THREADS-1:0] thread_mask;
    data_t [NUM_THREADS-1:0] rs1_bus;
    data_t [NUM_THREADS-1:0] rs2_bus;
    data_t [NUM_THREADS-1:0] imm_bus;
    logic                    issue_ack;
    data_t [NUM_THREADS-1:0] lsu_out_bus;

    // Operands of the next instruction
    data_t [NUM_THREADS-1:0] stim_rs1;
    data_t [NUM_THREADS-1:0] stim_rs2;
    data_t [NUM_THREADS-1:0] stim_imm;

    data_t model_mem [DATA_MEM_WORDS];
    int    error_count = 0;
    int    check_count = 0;
    int    cycle_count = 0;
    logic  ack_q = 1'b0;
    logic  req_q = 1'b0;

    lsu_cluster_top u_dut (
        .clk, .reset, .issue_req, .issue_op, .thread_mask,
        .rs1_bus, .rs2_bus, .imm_bus, .issue_ack, .lsu_out_bus
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Four-phase order of ack against the req seen one edge earlier
    always @(posedge clk) begin
        if (!reset) begin
            if (issue_ack && !ack_q && !req_q) begin
                $display("ERROR: issue_ack rose while issue_req was low");
                error_count++;
            end
            if (!issue_ack && ack_q && req_q) begin
                $display("ERROR: issue_ack fell while issue_req was still high");
                error_count++;
            end
        end
        ack_q <= issue_ack;
        req_q <= issue_req;
    end

    function automatic data_memory_address_t lane_address(input data_t rs1, input data_t imm);
        return data_memory_address_t'(rs1 + imm);
    endfunction

    // Effective addresses are distinct per lane and fall below span
    task automatic make_operands(input int span);
        data_memory_address_t addr;
        logic                 clash;
        for (int t = 0; t < NUM_THREADS; t++) begin
            stim_rs1[t] = data_t'($urandom);
            stim_rs2[t] = data_t'($urandom);
            do begin
                addr  = data_memory_address_t'($urandom % span);
                clash = 1'b0;
                for (int u = 0; u < t; u++) begin
                    if (lane_address(stim_rs1[u], stim_imm[u]) == addr) begin
                        clash = 1'b1;
                    end
                end
            end while (clash);
            stim_imm[t] = data_t'(addr - stim_rs1[t]);
        end
    endtask

    // Every lane points at one address through different rs1 values
    task automatic shared_address_operands(input data_memory_address_t addr);
        for (int t = 0; t < NUM_THREADS; t++) begin
            stim_rs1[t] = data_t'($urandom);
            stim_rs2[t] = data_t'($urandom);
            stim_imm[t] = data_t'(addr - stim_rs1[t]);
        end
    endtask

    task automatic issue_instr(input mem_op_t op, input logic [NUM_THREADS-1:0] mask);
        data_t                expected [NUM_THREADS];
        data_memory_address_t addr;
        // Predict the loads, then apply the stores of masked lanes
        for (int t = 0; t < NUM_THREADS; t++) begin
            addr        = lane_address(stim_rs1[t], stim_imm[t]);
            expected[t] = model_mem[addr];
            if (mask[t] && op == MEM_STORE) begin
                model_mem[addr] = stim_rs2[t];
            end
        end
        issue_op    = op;
        thread_mask = mask;
        rs1_bus     = stim_rs1;
        rs2_bus     = stim_rs2;
        imm_bus     = stim_imm;
        issue_req   = 1'b1;
        @(negedge clk);
        while (issue_ack !== 1'b1) begin
            @(negedge clk);
        end
        // lsu_out_bus holds the results while ack is high
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (mask[t] && op == MEM_LOAD) begin
                check_count++;
                if (lsu_out_bus[t] !== expected[t]) begin
                    $display("FAIL lsu_out_bus[%0d]: got %h, expected %h",
                             t, lsu_out_bus[t], expected[t]);
                    error_count++;
                end
            end
        end
        issue_req = 1'b0;
        @(negedge clk);
        while (issue_ack !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'h231074dd));
        clk         = 1'b0;
        reset       = 1'b1;
        issue_req   = 1'b0;
        issue_op    = MEM_LOAD;
        thread_mask = '0;
        rs1_bus     = '0;
        rs2_bus     = '0;
        imm_bus     = '0;
        for (int a = 0; a < DATA_MEM_WORDS; a++) begin
            model_mem[a] = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_count++;
        if (issue_ack !== 1'b0) begin
            $display("FAIL issue_ack after reset: got %h, expected 0", issue_ack);
            error_count++;
        end

        // Cleared memory reads back zero anywhere
        make_operands(DATA_MEM_WORDS);
        issue_instr(MEM_LOAD, '1);

        // Lane 2 is masked off, so its address keeps the old word
        make_operands(DATA_MEM_WORDS);
        issue_instr(MEM_STORE, 4'b1011);
        issue_instr(MEM_LOAD, '1);

        // Empty mask must leave memory untouched
        make_operands(16);
        issue_instr(MEM_STORE, '0);
        issue_instr(MEM_LOAD, '1);

        // All lanes contend for one word
        shared_address_operands(data_memory_address_t'($urandom));
        issue_instr(MEM_STORE, 4'b0001);
        issue_instr(MEM_LOAD, '1);

        // Small address window so loads often hit earlier stores
        repeat (NUM_RANDOM) begin
            make_operands(24);
            issue_instr(($urandom % 2 == 0) ? MEM_LOAD : MEM_STORE,
                        NUM_THREADS'($urandom));
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog/data_memory.sv */
`timescale 1ns/1ps

module data_memory
    import gpu_data_pkg::*;
#(
    parameter int MEM_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_valid,
    input  logic                 mem_write,
    input  data_memory_address_t mem_address,
    input  data_t                mem_wdata,
    output logic                 mem_ready,
    output data_t                mem_rdata
);

    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    data_t            mem [DATA_MEM_WORDS];
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            cnt       <= '0;
            for (int i = 0; i < DATA_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_ready) begin
            // Ready is a single cycle pulse
            mem_ready <= 1'b0;
            cnt       <= '0;
        end else if (mem_valid) begin
            if (cnt == CNT_W'(MEM_LATENCY - 1)) begin
                // Access lands together with the ready pulse
                mem_ready <= 1'b1;
                cnt       <= '0;
                mem_rdata <= mem[mem_address];
                if (mem_write) begin
                    mem[mem_address] <= mem_wdata;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* verilog/gpu_ctrl_pkg.sv */
package gpu_ctrl_pkg;

    // Warp progress through one memory instruction
    typedef enum logic [1:0] {
        WARP_IDLE    = 2'b00,
        WARP_REQUEST = 2'b01,
        WARP_WAIT    = 2'b10,
        WARP_UPDATE  = 2'b11
    } warp_state_t;

    // Per-thread load-store unit progress
    typedef enum logic [1:0] {
        LSU_IDLE       = 2'b00,
        LSU_REQUESTING = 2'b01,
        LSU_WAITING    = 2'b10,
        LSU_DONE       = 2'b11
    } lsu_state_t;

    // Kind of memory instruction issued to the warp
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_t;

endpackage

/* verilog/gpu_data_pkg.sv */
package gpu_data_pkg;

    // Width of one register value or memory word
    localparam int DATA_WIDTH = 8;

    // Address width of the shared data memory, one word per address
    localparam int DATA_ADDR_WIDTH = 8;

    // One register value or one memory word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Word address into the shared data memory
    typedef logic [DATA_ADDR_WIDTH-1:0] data_memory_address_t;

    // Number of words the data memory holds
    localparam int DATA_MEM_WORDS = 2 ** DATA_ADDR_WIDTH;

endpackage

/* verilog/lsu.sv */
`timescale 1ns/1ps

module lsu
    import gpu_data_pkg::*, gpu_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    // Low when this thread is masked off for the current instruction
    input  logic                 enable,

    input  warp_state_t          warp_state,
    input  logic                 decoded_mem_read_enable,
    input  logic                 decoded_mem_write_enable,

    input  data_t                rs1,
    input  data_t                rs2,
    input  data_t                imm,

    output logic                 mem_read_valid,
    output data_memory_address_t mem_read_address,
    input  logic                 mem_read_ready,
    input  data_t                mem_read_data,
    output logic                 mem_write_valid,
    output data_memory_address_t mem_write_address,
    output data_t                mem_write_data,
    input  logic                 mem_write_ready,

    output lsu_state_t           lsu_state,
    output data_t                lsu_out
);

    data_memory_address_t offset_address;
    logic                 read_done;
    logic                 write_done;

    // Effective address wraps at the top of the memory
    assign offset_address = rs1 + imm;

    assign read_done  = mem_read_valid && mem_read_ready;
    assign write_done = mem_write_valid && mem_write_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_state       <= LSU_IDLE;
            mem_read_valid  <= 1'b0;
            mem_write_valid <= 1'b0;
        end else begin
            case (lsu_state)
                LSU_IDLE: begin
                    // Start only in the warp's request cycle
                    if (enable && warp_state == WARP_REQUEST &&
                        (decoded_mem_read_enable || decoded_mem_write_enable)) begin
                        lsu_state <= LSU_REQUESTING;
                    end
                end
                LSU_REQUESTING: begin
                    mem_read_valid  <= decoded_mem_read_enable;
                    mem_write_valid <= decoded_mem_write_enable;
                    lsu_state       <= LSU_WAITING;
                end
                LSU_WAITING: begin
                    // Valid stays up until the memory side answers
                    if (read_done || write_done) begin
                        mem_read_valid  <= 1'b0;
                        mem_write_valid <= 1'b0;
                        lsu_state       <= LSU_DONE;
                    end
                end
                LSU_DONE: begin
                    if (warp_state == WARP_UPDATE) begin
                        lsu_state <= LSU_IDLE;
                    end
                end
                default: begin
                    lsu_state <= LSU_IDLE;
                end
            endcase
        end
    end

    // Request payload and the load result
    always_ff @(posedge clk) begin
        if (lsu_state == LSU_REQUESTING) begin
            mem_read_address  <= offset_address;
            mem_write_address <= offset_address;
            mem_write_data    <= rs2;
        end
        // Loaded word is kept until the next load completes
        if (lsu_state == LSU_WAITING && read_done) begin
            lsu_out <= mem_read_data;
        end
    end

endmodule

/* verilog/lsu_cluster_top.sv */
`timescale 1ns/1ps

module lsu_cluster_top
    import gpu_data_pkg::*, gpu_ctrl_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int MEM_LATENCY = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_req,
    input  mem_op_t                 issue_op,
    input  logic  [NUM_THREADS-1:0] thread_mask,
    input  data_t [NUM_THREADS-1:0] rs1_bus,
    input  data_t [NUM_THREADS-1:0] rs2_bus,
    input  data_t [NUM_THREADS-1:0] imm_bus,
    output logic                    issue_ack,
    output data_t [NUM_THREADS-1:0] lsu_out_bus
);

    warp_state_t                            warp_state;
    logic                                   read_enable;
    logic                                   write_enable;
    lsu_state_t           [NUM_THREADS-1:0] lsu_state_bus;

    logic                 [NUM_THREADS-1:0] mem_read_valid;
    data_memory_address_t [NUM_THREADS-1:0] mem_read_address;
    logic                 [NUM_THREADS-1:0] mem_read_ready;
    data_t                                  mem_read_data;
    logic                 [NUM_THREADS-1:0] mem_write_valid;
    data_memory_address_t [NUM_THREADS-1:0] mem_write_address;
    data_t                [NUM_THREADS-1:0] mem_write_data;
    logic                 [NUM_THREADS-1:0] mem_write_ready;

    logic                                   mem_valid;
    logic                                   mem_write;
    data_memory_address_t                   mem_address;
    data_t                                  mem_wdata;
    logic                                   mem_ready;
    data_t                                  mem_rdata;

    warp_scheduler #(.NUM_THREADS(NUM_THREADS)) u_scheduler (
        .clk, .reset, .issue_req, .issue_op, .thread_mask, .lsu_state_bus, .warp_state,
        .decoded_mem_read_enable(read_enable), .decoded_mem_write_enable(write_enable),
        .issue_ack
    );

    // One load-store unit per thread
    for (genvar t = 0; t < NUM_THREADS; t++) begin : g_lsu
        lsu u_lsu (
            .clk, .reset, .enable(thread_mask[t]), .warp_state,
            .decoded_mem_read_enable(read_enable), .decoded_mem_write_enable(write_enable),
            .rs1(rs1_bus[t]), .rs2(rs2_bus[t]), .imm(imm_bus[t]),
            .mem_read_valid(mem_read_valid[t]), .mem_read_address(mem_read_address[t]),
            .mem_read_ready(mem_read_ready[t]), .mem_read_data(mem_read_data),
            .mem_write_valid(mem_write_valid[t]), .mem_write_address(mem_write_address[t]),
            .mem_write_data(mem_write_data[t]), .mem_write_ready(mem_write_ready[t]),
            .lsu_state(lsu_state_bus[t]), .lsu_out(lsu_out_bus[t])
        );
    end

    mem_arbiter #(.NUM_THREADS(NUM_THREADS)) u_arbiter (
        .clk, .reset, .mem_read_valid, .mem_read_address, .mem_read_ready, .mem_read_data,
        .mem_write_valid, .mem_write_address, .mem_write_data, .mem_write_ready,
        .mem_valid, .mem_write, .mem_address, .mem_wdata, .mem_ready, .mem_rdata
    );

    data_memory #(.MEM_LATENCY(MEM_LATENCY)) u_memory (
        .clk, .reset, .mem_valid, .mem_write, .mem_address, .mem_wdata, .mem_ready, .mem_rdata
    );

endmodule

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import gpu_data_pkg::*;
#(
    parameter int NUM_THREADS = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                 [NUM_THREADS-1:0] mem_read_valid,
    input  data_memory_address_t [NUM_THREADS-1:0] mem_read_address,
    output logic                 [NUM_THREADS-1:0] mem_read_ready,
    output data_t                                  mem_read_data,
    input  logic                 [NUM_THREADS-1:0] mem_write_valid,
    input  data_memory_address_t [NUM_THREADS-1:0] mem_write_address,
    input  data_t                [NUM_THREADS-1:0] mem_write_data,
    output logic                 [NUM_THREADS-1:0] mem_write_ready,

    output logic                                   mem_valid,
    output logic                                   mem_write,
    output data_memory_address_t                   mem_address,
    output data_t                                  mem_wdata,
    input  logic                                   mem_ready,
    input  data_t                                  mem_rdata
);

    localparam int IDX_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    logic [NUM_THREADS-1:0] request;
    logic                   busy;
    logic [IDX_W-1:0]       grant_idx;
    logic [IDX_W-1:0]       pointer;
    logic                   pick_found;
    logic [IDX_W-1:0]       pick_idx;
    logic [IDX_W-1:0]       cur_idx;

    assign request = mem_read_valid | mem_write_valid;

    // First requester at or after the pointer, wrapping around
    always_comb begin
        int unsigned idx;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            idx = (int'(pointer) + i) % NUM_THREADS;
            if (!pick_found && request[idx]) begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(idx);
            end
        end
    end

    // While idle the pick goes straight to the memory, then it is locked
    assign cur_idx     = busy ? grant_idx : pick_idx;
    assign mem_valid   = busy || pick_found;
    assign mem_write   = mem_write_valid[cur_idx];
    assign mem_address = mem_write ? mem_write_address[cur_idx] : mem_read_address[cur_idx];
    assign mem_wdata   = mem_write_data[cur_idx];

    assign mem_read_data = mem_rdata;

    // Ready only reaches the owner of the port
    always_comb begin
        mem_read_ready  = '0;
        mem_write_ready = '0;
        if (busy && mem_ready) begin
            mem_read_ready[grant_idx]  = mem_read_valid[grant_idx];
            mem_write_ready[grant_idx] = mem_write_valid[grant_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            grant_idx <= '0;
            pointer   <= '0;
        end else if (busy) begin
            if (mem_ready) begin
                busy    <= 1'b0;
                pointer <= (grant_idx == IDX_W'(NUM_THREADS - 1)) ? '0 : grant_idx + 1'b1;
            end
        end else if (pick_found) begin
            busy      <= 1'b1;
            grant_idx <= pick_idx;
        end
    end

endmodule

/* verilog/warp_scheduler.sv */
`timescale 1ns/1ps

module warp_scheduler
    import gpu_ctrl_pkg::*;
#(
    parameter int NUM_THREADS = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         issue_req,
    input  mem_op_t                      issue_op,
    input  logic       [NUM_THREADS-1:0] thread_mask,
    input  lsu_state_t [NUM_THREADS-1:0] lsu_state_bus,
    output warp_state_t                  warp_state,
    output logic                         decoded_mem_read_enable,
    output logic                         decoded_mem_write_enable,
    output logic                         issue_ack
);

    logic all_done;

    // Masked-off threads never start, so they are not waited for
    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (thread_mask[i] && lsu_state_bus[i] != LSU_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_state               <= WARP_IDLE;
            decoded_mem_read_enable  <= 1'b0;
            decoded_mem_write_enable <= 1'b0;
            issue_ack                <= 1'b0;
        end else begin
            case (warp_state)
                WARP_IDLE: begin
                    if (issue_req) begin
                        decoded_mem_read_enable  <= (issue_op == MEM_LOAD);
                        decoded_mem_write_enable <= (issue_op == MEM_STORE);
                        if (|thread_mask) begin
                            warp_state <= WARP_REQUEST;
                        end else begin
                            // Nothing to do for an empty mask
                            warp_state <= WARP_UPDATE;
                            issue_ack  <= 1'b1;
                        end
                    end
                end
                WARP_REQUEST: begin
                    warp_state <= WARP_WAIT;
                end
                WARP_WAIT: begin
                    if (all_done) begin
                        warp_state <= WARP_UPDATE;
                        issue_ack  <= 1'b1;
                    end
                end
                WARP_UPDATE: begin
                    // Close the four-phase handshake
                    if (!issue_req) begin
                        warp_state               <= WARP_IDLE;
                        issue_ack                <= 1'b0;
                        decoded_mem_read_enable  <= 1'b0;
                        decoded_mem_write_enable <= 1'b0;
                    end
                end
                default: begin
                    warp_state <= WARP_IDLE;
                end
            endcase
        end
    end

endmodule
